// File: source/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int xlen         = 32;
    localparam int reg_count    = 32;
    localparam int reg_idx_bits = 5;
    localparam int rob_depth    = 8;
    localparam int rob_idx_bits = 3;
    localparam int tag_bits     = 4;
    localparam int rs_depth     = 4;
    localparam int rs_idx_bits  = 2;
    localparam int alu_op_bits  = 4;

    // ALU operation codes
    localparam logic [alu_op_bits-1:0] alu_add = 4'd0;
    localparam logic [alu_op_bits-1:0] alu_sub = 4'd1;
    localparam logic [alu_op_bits-1:0] alu_and = 4'd2;
    localparam logic [alu_op_bits-1:0] alu_or  = 4'd3;
    localparam logic [alu_op_bits-1:0] alu_xor = 4'd4;
    localparam logic [alu_op_bits-1:0] alu_slt = 4'd5;
    localparam logic [alu_op_bits-1:0] alu_sll = 4'd6;
    localparam logic [alu_op_bits-1:0] alu_srl = 4'd7;

    // MIPS major opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_xori  = 6'h0e;

    // R-type function field
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_slt = 6'h2a;

    // Same word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [reg_idx_bits-1:0] rs;
            logic [reg_idx_bits-1:0] rt;
            logic [reg_idx_bits-1:0] rd;
            logic [reg_idx_bits-1:0] shamt;
            logic [5:0]              funct;
        } r;
        struct packed {
            logic [5:0]              opcode;
            logic [reg_idx_bits-1:0] rs;
            logic [reg_idx_bits-1:0] rt;
            logic [15:0]             imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

// File: source/issue_decode.sv
`timescale 1ns/1ps
`default_nettype none

module issue_decode import ooo_pkg::*; (
    input  logic                    issue_valid,
    input  instr_t                  issue_instr,
    input  logic                    rob_full,
    input  logic                    rs_full,
    output logic                    stall,
    output logic                    alloc,
    output logic [reg_idx_bits-1:0] src_a,
    output logic [reg_idx_bits-1:0] src_b,
    output logic [reg_idx_bits-1:0] dest,
    output logic [alu_op_bits-1:0]  alu_op,
    output logic                    use_imm,
    output logic [xlen-1:0]         imm
);

    logic is_rtype;
    logic is_shift;
    logic zero_ext;

    assign stall = rob_full | rs_full;
    assign alloc = issue_valid & ~stall;

    assign is_rtype = (issue_instr.r.opcode == op_rtype);
    assign is_shift = is_rtype && (issue_instr.r.funct inside {fn_sll, fn_srl});
    assign zero_ext = issue_instr.i.opcode inside {op_andi, op_ori, op_xori};

    // Shifts take the shifted value from rt
    assign src_a   = is_shift ? issue_instr.r.rt : issue_instr.r.rs;
    assign src_b   = issue_instr.r.rt;
    assign dest    = is_rtype ? issue_instr.r.rd : issue_instr.i.rt;
    assign use_imm = ~is_rtype | is_shift;

    always_comb begin
        if (is_shift)
            imm = xlen'(issue_instr.r.shamt);
        else if (zero_ext)
            imm = {{(xlen-16){1'b0}}, issue_instr.i.imm};
        else
            imm = {{(xlen-16){issue_instr.i.imm[15]}}, issue_instr.i.imm};
    end

    always_comb begin
        alu_op = alu_add;
        case (issue_instr.i.opcode)
            op_slti: alu_op = alu_slt;
            op_andi: alu_op = alu_and;
            op_ori:  alu_op = alu_or;
            op_xori: alu_op = alu_xor;
            op_rtype: begin
                case (issue_instr.r.funct)
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    default: alu_op = alu_add;
                endcase
            end
            default: alu_op = alu_add;
        endcase
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import ooo_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc,
    input  logic [reg_idx_bits-1:0] src_a,
    input  logic [reg_idx_bits-1:0] src_b,
    input  logic [reg_idx_bits-1:0] dest,
    input  logic [tag_bits-1:0]     new_tag,
    input  logic                    commit_valid,
    input  logic [reg_idx_bits-1:0] commit_rd,
    input  logic [tag_bits-1:0]     commit_tag,
    input  logic [xlen-1:0]         commit_data,
    output logic [xlen-1:0]         a_val,
    output logic [xlen-1:0]         b_val,
    output logic [tag_bits-1:0]     a_tag,
    output logic [tag_bits-1:0]     b_tag
);

    logic [xlen-1:0]     regs [reg_count];
    // Nonzero tag names the ROB entry that will produce the value
    logic [tag_bits-1:0] tags [reg_count];

    assign a_val = regs[src_a];
    assign b_val = regs[src_b];
    assign a_tag = tags[src_a];
    assign b_tag = tags[src_b];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            // Only the newest producer of a register may clear its tag
            if (commit_valid && commit_rd != '0 && tags[commit_rd] == commit_tag) begin
                regs[commit_rd] <= commit_data;
                tags[commit_rd] <= '0;
            end
            // Rename in the same cycle overrides the clear
            if (alloc && dest != '0)
                tags[dest] <= new_tag;
        end
    end

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc,
    input  logic [reg_idx_bits-1:0] dest,
    input  logic [tag_bits-1:0]     a_tag,
    input  logic [tag_bits-1:0]     b_tag,
    input  logic                    cdb_valid,
    input  logic [tag_bits-1:0]     cdb_tag,
    input  logic [xlen-1:0]         cdb_data,
    output logic                    rob_full,
    output logic [tag_bits-1:0]     new_tag,
    output logic                    a_ready,
    output logic                    b_ready,
    output logic [xlen-1:0]         a_data,
    output logic [xlen-1:0]         b_data,
    output logic                    commit_valid,
    output logic [reg_idx_bits-1:0] commit_rd,
    output logic [tag_bits-1:0]     commit_tag,
    output logic [xlen-1:0]         commit_data
);

    logic [rob_depth-1:0]    busy;
    logic [rob_depth-1:0]    ready;
    logic [reg_idx_bits-1:0] entry_rd   [rob_depth];
    logic [xlen-1:0]         entry_data [rob_depth];
    logic [rob_idx_bits-1:0] head;
    logic [rob_idx_bits-1:0] tail;
    logic [rob_idx_bits:0]   count;
    logic [rob_idx_bits-1:0] a_idx;
    logic [rob_idx_bits-1:0] b_idx;
    logic [rob_idx_bits-1:0] cdb_idx;

    // Tag is slot plus one, zero is reserved for the register file
    assign a_idx   = rob_idx_bits'(a_tag - tag_bits'(1));
    assign b_idx   = rob_idx_bits'(b_tag - tag_bits'(1));
    assign cdb_idx = rob_idx_bits'(cdb_tag - tag_bits'(1));
    assign new_tag = tag_bits'(tail) + tag_bits'(1);

    assign rob_full = (count == (rob_idx_bits + 1)'(rob_depth));

    // Lookups see the entry even while it retires
    assign a_ready = ready[a_idx];
    assign b_ready = ready[b_idx];
    assign a_data  = entry_data[a_idx];
    assign b_data  = entry_data[b_idx];

    assign commit_valid = busy[head] & ready[head];
    assign commit_rd    = entry_rd[head];
    assign commit_tag   = tag_bits'(head) + tag_bits'(1);
    assign commit_data  = entry_data[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= '0;
            ready <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (cdb_valid)
                ready[cdb_idx] <= 1'b1;
            if (commit_valid) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (alloc) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                tail        <= tail + 1'b1;
            end
            count <= count + {{rob_idx_bits{1'b0}}, alloc}
                           - {{rob_idx_bits{1'b0}}, commit_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_valid)
            entry_data[cdb_idx] <= cdb_data;
        if (alloc)
            entry_rd[tail] <= dest;
    end

endmodule

`default_nettype wire

// File: source/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc,
    input  logic [alu_op_bits-1:0] alu_op,
    input  logic                   use_imm,
    input  logic [xlen-1:0]        imm,
    input  logic [xlen-1:0]        a_val,
    input  logic [xlen-1:0]        b_val,
    input  logic [tag_bits-1:0]    a_tag,
    input  logic [tag_bits-1:0]    b_tag,
    input  logic                   a_ready,
    input  logic                   b_ready,
    input  logic [xlen-1:0]        a_data,
    input  logic [xlen-1:0]        b_data,
    input  logic [tag_bits-1:0]    new_tag,
    input  logic                   cdb_valid,
    input  logic [tag_bits-1:0]    cdb_tag,
    input  logic [xlen-1:0]        cdb_data,
    output logic                   rs_full,
    output logic                   dispatch_valid,
    output logic [alu_op_bits-1:0] disp_op,
    output logic [xlen-1:0]        disp_a,
    output logic [xlen-1:0]        disp_b,
    output logic [tag_bits-1:0]    disp_tag
);

    logic [rs_depth-1:0]    valid;
    logic [rs_depth-1:0]    a_rdy;
    logic [rs_depth-1:0]    b_rdy;
    logic [alu_op_bits-1:0] e_op   [rs_depth];
    logic [tag_bits-1:0]    e_tag  [rs_depth];
    logic [tag_bits-1:0]    a_wait [rs_depth];
    logic [tag_bits-1:0]    b_wait [rs_depth];
    logic [xlen-1:0]        a_opnd [rs_depth];
    logic [xlen-1:0]        b_opnd [rs_depth];
    // older[i][j] set when entry i was issued before entry j
    logic [rs_depth-1:0]    older  [rs_depth];
    logic [rs_depth-1:0]    ready;
    logic [rs_depth-1:0]    pick;
    logic [rs_depth-1:0]    wake_a;
    logic [rs_depth-1:0]    wake_b;
    logic [rs_idx_bits-1:0] sel_idx;
    logic [rs_idx_bits-1:0] free_idx;
    logic [xlen:0]          new_a;
    logic [xlen:0]          new_b;

    // Returns {ready, value} from the register file, the ROB or a CDB hit this cycle
    function automatic logic [xlen:0] resolve(input logic [xlen-1:0] rf_val,
                                               input logic [tag_bits-1:0] tag,
                                               input logic rob_rdy,
                                               input logic [xlen-1:0] rob_val);
        if (tag == '0)
            return {1'b1, rf_val};
        if (rob_rdy)
            return {1'b1, rob_val};
        if (cdb_valid && cdb_tag == tag)
            return {1'b1, cdb_data};
        return {1'b0, rf_val};
    endfunction

    always_comb begin
        new_a = resolve(a_val, a_tag, a_ready, a_data);
        if (use_imm)
            new_b = {1'b1, imm};
        else
            new_b = resolve(b_val, b_tag, b_ready, b_data);
    end

    always_comb begin
        ready  = valid & a_rdy & b_rdy;
        wake_a = '0;
        wake_b = '0;
        pick   = '0;
        for (int i = 0; i < rs_depth; i++) begin
            wake_a[i] = valid[i] && !a_rdy[i] && cdb_valid && cdb_tag == a_wait[i];
            wake_b[i] = valid[i] && !b_rdy[i] && cdb_valid && cdb_tag == b_wait[i];
            // Ready and no older ready entry
            pick[i] = ready[i] && ((ready & older_col(i)) == '0);
        end
        sel_idx  = '0;
        free_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (pick[i])
                sel_idx = rs_idx_bits'(i);
            if (!valid[i])
                free_idx = rs_idx_bits'(i);
        end
    end

    // Entries older than entry i
    function automatic logic [rs_depth-1:0] older_col(input int i);
        logic [rs_depth-1:0] col;
        for (int j = 0; j < rs_depth; j++)
            col[j] = older[j][i];
        return col;
    endfunction

    assign rs_full        = &valid;
    assign dispatch_valid = |ready;
    assign disp_op        = e_op[sel_idx];
    assign disp_a         = a_opnd[sel_idx];
    assign disp_b         = b_opnd[sel_idx];
    assign disp_tag       = e_tag[sel_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            a_rdy <= '0;
            b_rdy <= '0;
            for (int i = 0; i < rs_depth; i++)
                older[i] <= '0;
        end else begin
            a_rdy <= a_rdy | wake_a;
            b_rdy <= b_rdy | wake_b;
            if (dispatch_valid)
                valid[sel_idx] <= 1'b0;
            if (alloc) begin
                valid[free_idx] <= 1'b1;
                a_rdy[free_idx] <= new_a[xlen];
                b_rdy[free_idx] <= new_b[xlen];
                older[free_idx] <= '0;
                // Everything already waiting is older than the new entry
                for (int j = 0; j < rs_depth; j++)
                    older[j][free_idx] <= valid[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (wake_a[i])
                a_opnd[i] <= cdb_data;
            if (wake_b[i])
                b_opnd[i] <= cdb_data;
        end
        if (alloc) begin
            e_op[free_idx]   <= alu_op;
            e_tag[free_idx]  <= new_tag;
            a_wait[free_idx] <= a_tag;
            b_wait[free_idx] <= b_tag;
            a_opnd[free_idx] <= new_a[xlen-1:0];
            b_opnd[free_idx] <= new_b[xlen-1:0];
        end
    end

endmodule

`default_nettype wire

// File: source/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dispatch_valid,
    input  logic [alu_op_bits-1:0] disp_op,
    input  logic [xlen-1:0]        disp_a,
    input  logic [xlen-1:0]        disp_b,
    input  logic [tag_bits-1:0]    disp_tag,
    output logic                   cdb_valid,
    output logic [tag_bits-1:0]    cdb_tag,
    output logic [xlen-1:0]        cdb_data
);

    logic [xlen-1:0] result;

    always_comb begin
        case (disp_op)
            alu_sub: result = disp_a - disp_b;
            alu_and: result = disp_a & disp_b;
            alu_or:  result = disp_a | disp_b;
            alu_xor: result = disp_a ^ disp_b;
            alu_slt: result = xlen'($signed(disp_a) < $signed(disp_b));
            alu_sll: result = disp_a << disp_b[4:0];
            alu_srl: result = disp_a >> disp_b[4:0];
            default: result = disp_a + disp_b;
        endcase
    end

    // Single result bus, valid the cycle after dispatch
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= dispatch_valid;
    end

    always_ff @(posedge clk) begin
        cdb_tag  <= disp_tag;
        cdb_data <= result;
    end

endmodule

`default_nettype wire

// File: source/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  instr_t                  issue_instr,
    output logic                    stall,
    output logic                    commit_valid,
    output logic [reg_idx_bits-1:0] commit_rd,
    output logic [xlen-1:0]         commit_data
);

    // Decode to rename
    logic                    alloc;
    logic                    rob_full;
    logic                    rs_full;
    logic [reg_idx_bits-1:0] src_a;
    logic [reg_idx_bits-1:0] src_b;
    logic [reg_idx_bits-1:0] dest;
    logic [alu_op_bits-1:0]  alu_op;
    logic                    use_imm;
    logic [xlen-1:0]         imm;

    // Operand sources
    logic [xlen-1:0]         a_val;
    logic [xlen-1:0]         b_val;
    logic [tag_bits-1:0]     a_tag;
    logic [tag_bits-1:0]     b_tag;
    logic [tag_bits-1:0]     new_tag;
    logic                    a_ready;
    logic                    b_ready;
    logic [xlen-1:0]         a_data;
    logic [xlen-1:0]         b_data;
    logic [tag_bits-1:0]     commit_tag;

    // Dispatch and CDB
    logic                    dispatch_valid;
    logic [alu_op_bits-1:0]  disp_op;
    logic [xlen-1:0]         disp_a;
    logic [xlen-1:0]         disp_b;
    logic [tag_bits-1:0]     disp_tag;
    logic                    cdb_valid;
    logic [tag_bits-1:0]     cdb_tag;
    logic [xlen-1:0]         cdb_data;

    issue_decode i_issue_decode (.*);

    reg_file i_reg_file (.*);

    reorder_buffer i_reorder_buffer (.*);

    reservation_station i_reservation_station (.*);

    alu_unit i_alu_unit (.*);

endmodule

`default_nettype wire

// File: tb/ooo_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_properties import ooo_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  commit_valid,
    input logic [rob_idx_bits:0] count
);

    // Occupancy bounded by the ROB size
    assert property (@(posedge clk) disable iff (rst)
                     count <= (rob_idx_bits + 1)'(rob_depth))
        else $error("ROB count exceeds depth: %0d", count);

    // Retire needs a live entry
    assert property (@(posedge clk) disable iff (rst) commit_valid |-> count != '0)
        else $error("ROB commit with empty buffer");

    assert property (@(posedge clk) rst |-> !commit_valid)
        else $error("ROB commit while in reset");

endmodule

bind reorder_buffer ooo_core_properties i_ooo_core_properties (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit_valid),
    .count        (count)
);

`default_nettype wire

// File: tb/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

    localparam int hand_count = 22;
    localparam int rand_count = 200;
    localparam int num_tests  = hand_count + rand_count;
    localparam logic [5:0] funct_list [8] = '{fn_add, fn_sub, fn_and, fn_or,
                                              fn_xor, fn_slt, fn_sll, fn_srl};
    localparam logic [5:0] iop_list [5] = '{op_addi, op_slti, op_andi, op_ori, op_xori};

    logic                    clk;
    logic                    rst;
    logic                    issue_valid;
    instr_t                  issue_instr;
    logic                    stall;
    logic                    commit_valid;
    logic [reg_idx_bits-1:0] commit_rd;
    logic [xlen-1:0]         commit_data;

    // Stimulus table and the expected commit stream
    instr_t                  prog     [num_tests];
    logic [reg_idx_bits-1:0] exp_rd   [num_tests];
    logic [xlen-1:0]         exp_data [num_tests];
    logic [xlen-1:0]         model_regs [reg_count];
    logic [15:0]             lfsr;
    int                      checks;
    int                      errors;
    int                      err_before;
    int                      commit_count;
    bit                      taken;

    ooo_core i_ooo_core (.*);

    always #50 clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hB400 : 16'h0000);
        return out;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic instr_t make_rtype(input logic [5:0] funct, input int rs, input int rt,
                                          input int rd, input int shamt);
        instr_t w;
        w.r.opcode = op_rtype;
        w.r.rs     = reg_idx_bits'(rs);
        w.r.rt     = reg_idx_bits'(rt);
        w.r.rd     = reg_idx_bits'(rd);
        w.r.shamt  = reg_idx_bits'(shamt);
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic instr_t make_itype(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rs     = reg_idx_bits'(rs);
        w.i.rt     = reg_idx_bits'(rt);
        w.i.imm    = imm;
        return w;
    endfunction

    // MIPS semantics for the supported subset
    function automatic logic [xlen-1:0] model_exec(input instr_t ins, input logic [xlen-1:0] rs_v,
                                                   input logic [xlen-1:0] rt_v);
        logic [xlen-1:0] sx;
        logic [xlen-1:0] zx;
        sx = {{16{ins.i.imm[15]}}, ins.i.imm};
        zx = {16'h0000, ins.i.imm};
        case (ins.i.opcode)
            op_addi: return rs_v + sx;
            op_slti: return ($signed(rs_v) < $signed(sx)) ? 32'd1 : 32'd0;
            op_andi: return rs_v & zx;
            op_ori:  return rs_v | zx;
            op_xori: return rs_v ^ zx;
            default: begin
                case (ins.r.funct)
                    fn_sub:  return rs_v - rt_v;
                    fn_and:  return rs_v & rt_v;
                    fn_or:   return rs_v | rt_v;
                    fn_xor:  return rs_v ^ rt_v;
                    fn_slt:  return ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                    fn_sll:  return rt_v << ins.r.shamt;
                    fn_srl:  return rt_v >> ins.r.shamt;
                    default: return rs_v + rt_v;
                endcase
            end
        endcase
    endfunction

    task automatic compare_rd(input int idx, input logic [reg_idx_bits-1:0] got,
                              input logic [reg_idx_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail commit_rd test %0d: expected %h got %h", idx, exp, got);
        end
    endtask

    task automatic compare_data(input int idx, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail commit_data test %0d: expected %h got %h", idx, exp, got);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h got %h", name, exp, got);
        end
    endtask

    task automatic build_table();
        int sel;
        prog[0]  = make_itype(op_addi, 0, 1, 16'h1234);
        prog[1]  = make_itype(op_addi, 0, 2, 16'hfffb);
        prog[2]  = make_itype(op_ori, 0, 3, 16'h8001);
        prog[3]  = make_itype(op_andi, 2, 4, 16'hf0f0);
        prog[4]  = make_itype(op_xori, 2, 5, 16'h8000);
        prog[5]  = make_itype(op_slti, 2, 6, 16'h0001);
        prog[6]  = make_itype(op_slti, 1, 7, 16'h8000);
        prog[7]  = make_rtype(fn_add, 1, 2, 8, 0);
        prog[8]  = make_rtype(fn_sub, 1, 3, 9, 0);
        prog[9]  = make_rtype(fn_and, 1, 3, 10, 0);
        prog[10] = make_rtype(fn_or, 1, 3, 11, 0);
        prog[11] = make_rtype(fn_xor, 2, 3, 12, 0);
        prog[12] = make_rtype(fn_slt, 2, 1, 13, 0);
        prog[13] = make_rtype(fn_slt, 1, 2, 14, 0);
        prog[14] = make_rtype(fn_sll, 0, 1, 15, 4);
        prog[15] = make_rtype(fn_srl, 0, 2, 16, 28);
        // Dependent chain on r17 then a write to r0 and a read of it
        prog[16] = make_itype(op_addi, 0, 17, 16'h0001);
        prog[17] = make_rtype(fn_add, 17, 17, 17, 0);
        prog[18] = make_rtype(fn_add, 17, 17, 17, 0);
        prog[19] = make_rtype(fn_sub, 17, 1, 18, 0);
        prog[20] = make_itype(op_addi, 1, 0, 16'h0007);
        prog[21] = make_rtype(fn_add, 0, 1, 19, 0);
        // Random part uses r0..r7 so dependencies stay dense
        for (int n = hand_count; n < num_tests; n++) begin
            sel = int'(take_bits(4)) % 13;
            if (sel < 8)
                prog[n] = make_rtype(funct_list[sel], int'(take_bits(3)), int'(take_bits(3)),
                                     int'(take_bits(3)), (sel >= 6) ? int'(take_bits(5)) : 0);
            else
                prog[n] = make_itype(iop_list[sel-8], int'(take_bits(3)), int'(take_bits(3)),
                                     16'(take_bits(16)));
        end
    endtask

    task automatic run_model();
        for (int r = 0; r < reg_count; r++)
            model_regs[r] = '0;
        for (int n = 0; n < num_tests; n++) begin
            exp_data[n] = model_exec(prog[n], model_regs[prog[n].r.rs], model_regs[prog[n].r.rt]);
            exp_rd[n]   = (prog[n].r.opcode == op_rtype) ? prog[n].r.rd : prog[n].i.rt;
            if (exp_rd[n] != '0)
                model_regs[exp_rd[n]] = exp_data[n];
        end
    endtask

    // Every retirement is matched against the next table entry
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (commit_count >= num_tests) begin
                errors++;
                $display("Error: a commit arrived after the last instruction had retired");
            end else begin
                err_before = errors;
                compare_rd(commit_count, commit_rd, exp_rd[commit_count]);
                compare_data(commit_count, commit_data, exp_data[commit_count]);
                $display("test %0d: rd %0d data %h %s", commit_count, commit_rd, commit_data,
                         (errors == err_before) ? "ok" : "mismatch");
            end
            commit_count++;
        end
    end

    initial begin
        repeat (8 + 20 * num_tests) @(posedge clk);
        $display("Error: watchdog expired before all instructions committed");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_instr  = '0;
        lfsr         = 16'd65242;
        checks       = 0;
        errors       = 0;
        commit_count = 0;
        build_table();
        run_model();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        // Idle core after reset
        repeat (3) begin
            @(negedge clk);
            compare_bit("stall", stall, 1'b0);
            compare_bit("commit_valid", commit_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        for (int n = 0; n < num_tests; n++) begin
            issue_valid = 1'b1;
            issue_instr = prog[n];
            do begin
                @(negedge clk);
                taken = !stall;
                @(posedge clk);
                #1;
            end while (!taken);
        end
        issue_valid = 1'b0;
        issue_instr = '0;
        wait (commit_count >= num_tests);
        repeat (10) @(posedge clk);
        $display("checks %0d, errors %0d, commits %0d of %0d",
                 checks, errors, commit_count, num_tests);
        if (errors == 0 && commit_count == num_tests)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/ooo_pkg.sv
source/issue_decode.sv
source/reg_file.sv
source/reorder_buffer.sv
source/reservation_station.sv
source/alu_unit.sv
source/ooo_core.sv
tb/ooo_core_properties.sv
tb/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ooo_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb \
    -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vooo_core_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
